// File: files.f
+incdir+sim
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/regfile.sv
logic/decode_stage.sv
logic/hazard_ctrl.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/fetch_stage.sv
  - logic/regfile.sv
  - logic/decode_stage.sv
  - logic/hazard_ctrl.sv
  - logic/execute_stage.sv
  - logic/mem_wb_stage.sv
  - logic/rv_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/rv_core_tb.sv

// File: sim/rv_test_progs.svh
`ifndef RV_TEST_PROGS_SVH
`define RV_TEST_PROGS_SVH

localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_JALR  = 7'b1100111;

localparam int NUM_TESTS = 4;

function automatic string test_name(input int t);
    case (t)
        0:       return "alu_forwarding";
        1:       return "load_use";
        2:       return "branches";
        default: return "jumps";
    endcase
endfunction

function automatic int prog_words(input int t);
    case (t)
        0:       return 12;
        1:       return 6;
        2:       return 12;
        default: return 10;
    endcase
endfunction

// rom is cleared and ram preloaded before this runs
task automatic load_program(input int t);
    rv_pkg::word_t sum;
    case (t)
        0: begin
            rom[0]  = i_type(5, 0, 3'b000, 1, OPC_IMM);
            rom[1]  = i_type(-12, 1, 3'b000, 2, OPC_IMM);
            rom[2]  = r_type(7'h00, 2, 1, 3'b000, 3);
            rom[3]  = r_type(7'h20, 1, 3, 3'b000, 4);
            rom[4]  = r_type(7'h00, 1, 4, 3'b100, 5);
            rom[5]  = r_type(7'h00, 1, 5, 3'b010, 6);
            rom[6]  = r_type(7'h20, 6, 5, 3'b101, 7);
            rom[7]  = u_type(20'h12345, 8, OPC_LUI);
            rom[8]  = i_type(1, 8, 3'b000, 0, OPC_IMM);
            rom[9]  = s_type(32'h40, 0, 0);
            rom[10] = r_type(7'h00, 7, 8, 3'b000, 9);
            rom[11] = s_type(32'h48, 9, 0);
            expect_write(1, 32'h0000_0005);
            expect_write(2, 32'hffff_fff9);
            expect_write(3, 32'hffff_fffe);
            expect_write(4, 32'hffff_fff9);
            expect_write(5, 32'hffff_fffc);
            expect_write(6, 32'h0000_0001);
            expect_write(7, 32'hffff_fffe);
            expect_write(8, 32'h1234_5000);
            expect_store(32'h40, 32'h0000_0000);
            expect_write(9, 32'h1234_4ffe);
            expect_store(32'h48, 32'h1234_4ffe);
        end
        1: begin
            rom[0] = i_type(32'h20, 0, 3'b010, 1, OPC_LOAD);
            rom[1] = i_type(32'h24, 0, 3'b010, 2, OPC_LOAD);
            rom[2] = r_type(7'h00, 2, 1, 3'b000, 3);
            rom[3] = s_type(32'h80, 3, 0);
            rom[4] = i_type(32'h80, 0, 3'b010, 4, OPC_LOAD);
            rom[5] = s_type(32'h84, 4, 0);
            sum = ram[8] + ram[9];
            expect_write(1, ram[8]);
            expect_write(2, ram[9]);
            expect_write(3, sum);
            expect_store(32'h80, sum);
            expect_write(4, sum);
            expect_store(32'h84, sum);
        end
        2: begin
            rom[0]  = i_type(3, 0, 3'b000, 1, OPC_IMM);
            rom[1]  = i_type(3, 0, 3'b000, 2, OPC_IMM);
            rom[2]  = b_type(12, 2, 1, 3'b000);
            rom[3]  = i_type(1, 0, 3'b000, 10, OPC_IMM);
            rom[4]  = s_type(32'h90, 1, 0);
            rom[5]  = i_type(-1, 0, 3'b000, 3, OPC_IMM);
            rom[6]  = b_type(12, 1, 3, 3'b100);
            rom[7]  = i_type(2, 0, 3'b000, 11, OPC_IMM);
            rom[8]  = i_type(3, 0, 3'b000, 12, OPC_IMM);
            rom[9]  = b_type(12, 2, 1, 3'b001);
            rom[10] = i_type(4, 0, 3'b000, 4, OPC_IMM);
            rom[11] = s_type(32'h94, 4, 0);
            expect_write(1, 32'h0000_0003);
            expect_write(2, 32'h0000_0003);
            expect_write(3, 32'hffff_ffff);
            expect_write(4, 32'h0000_0004);
            expect_store(32'h94, 32'h0000_0004);
        end
        default: begin
            rom[0] = j_type(12, 1);
            rom[1] = i_type(1, 0, 3'b000, 10, OPC_IMM);
            rom[2] = i_type(2, 0, 3'b000, 11, OPC_IMM);
            rom[3] = i_type(32'h20, 0, 3'b000, 2, OPC_IMM);
            rom[4] = i_type(0, 2, 3'b000, 3, OPC_JALR);
            rom[5] = i_type(3, 0, 3'b000, 12, OPC_IMM);
            rom[6] = i_type(4, 0, 3'b000, 13, OPC_IMM);
            rom[7] = s_type(32'ha0, 0, 0);
            rom[8] = s_type(32'ha4, 1, 0);
            rom[9] = s_type(32'ha8, 3, 0);
            expect_write(1, 32'h0000_0004);
            expect_write(2, 32'h0000_0020);
            expect_write(3, 32'h0000_0014);
            expect_store(32'ha4, 32'h0000_0004);
            expect_store(32'ha8, 32'h0000_0014);
        end
    endcase
endtask

`endif

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam rv_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 12;

    typedef struct packed {
        logic          is_store;
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
    } event_t;

    typedef struct packed {
        logic          re;
        logic          we;
        rv_pkg::word_t addr;
        rv_pkg::word_t wdata;
    } data_req_t;

    logic              clk;
    logic              rst_n;
    logic              imem_req_o;
    rv_pkg::word_t     imem_addr_o;
    rv_pkg::word_t     imem_rdata_i;
    logic              dmem_re_o;
    logic              dmem_we_o;
    rv_pkg::word_t     dmem_addr_o;
    rv_pkg::word_t     dmem_wdata_o;
    rv_pkg::word_t     dmem_rdata_i;
    logic              wb_we_o;
    rv_pkg::reg_addr_t wb_rd_o;
    rv_pkg::word_t     wb_data_o;

    rv_pkg::word_t rom [0:255];
    rv_pkg::word_t ram [0:255];
    event_t        exp_q [$];
    string         cur_name;
    logic [31:0]   lfsr_state;
    logic          fetch_pend;
    rv_pkg::word_t fetch_addr;
    data_req_t     data_pend;
    int            err_count;
    int            fail_count;
    int            check_count;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .imem_req_o(imem_req_o),
        .imem_addr_o(imem_addr_o),
        .imem_rdata_i(imem_rdata_i),
        .dmem_re_o(dmem_re_o),
        .dmem_we_o(dmem_we_o),
        .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o),
        .dmem_rdata_i(dmem_rdata_i),
        .wb_we_o(wb_we_o),
        .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t i_type(input int imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t s_type(input int imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2, rs1, 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t b_type(input int imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [19:0] upper, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {upper, rd, op};
    endfunction

    function automatic rv_pkg::word_t j_type(input int imm, input logic [4:0] rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
    endfunction

    `include "rv_test_progs.svh"

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output rv_pkg::word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic preload_ram();
        lfsr_state = 32'h8d45;
        for (int i = 0; i < 256; i++) begin
            draw_word(ram[i]);
        end
    endtask

    task automatic clear_rom();
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
    endtask

    task automatic expect_write(input logic [4:0] rd, input rv_pkg::word_t data);
        exp_q.push_back({1'b0, 27'b0, rd, data});
    endtask

    task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        exp_q.push_back({1'b1, addr, data});
    endtask

    task automatic check_quiet(input string when);
        assert (!dmem_we_o && !dmem_re_o && !imem_req_o && !wb_we_o) else begin
            $display("%s: a request or write output is high %s", cur_name, when);
            err_count++;
        end
    endtask

    task automatic check_event(input logic is_store, input rv_pkg::word_t addr,
                               input rv_pkg::word_t data);
        event_t exp;
        check_count++;
        assert (exp_q.size() != 0) else begin
            $display("%s: unexpected %s at %h after the last expected event", cur_name,
                     is_store ? "store" : "register write", addr);
            err_count++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (exp.is_store == is_store) else begin
                $display("%s: got a %s where the other kind of event was due", cur_name,
                         is_store ? "store" : "register write");
                err_count++;
            end
            assert (exp.addr == addr) else begin
                $display("ERR %s: target expected %h actual %h", cur_name, exp.addr, addr);
                err_count++;
            end
            assert (exp.data == data) else begin
                $display("ERR %s: data expected %h actual %h", cur_name, exp.data, data);
                err_count++;
            end
        end
    endtask

    // sample requests mid-cycle, answer on the next edge
    always @(negedge clk) begin
        fetch_pend <= imem_req_o;
        fetch_addr <= imem_addr_o;
        data_pend  <= {dmem_re_o, dmem_we_o, dmem_addr_o, dmem_wdata_o};
    end

    always @(posedge clk) begin
        if (fetch_pend) begin
            imem_rdata_i <= #1 rom[fetch_addr[9:2]];
        end
        if (data_pend.re) begin
            dmem_rdata_i <= #1 ram[data_pend.addr[9:2]];
        end
        if (data_pend.we) begin
            ram[data_pend.addr[9:2]] <= data_pend.wdata;
        end
    end

    // older instruction in WB goes first
    always @(negedge clk) begin
        if (!rst_n) begin
            check_quiet("during reset");
        end else begin
            if (wb_we_o) begin
                check_event(1'b0, {27'b0, wb_rd_o}, wb_data_o);
            end
            if (dmem_we_o) begin
                check_event(1'b1, dmem_addr_o, dmem_wdata_o);
            end
        end
    end

    task automatic run_test(input int t);
        int errs_before;
        errs_before = err_count;
        @(posedge clk);
        #1 rst_n = 1'b0;
        cur_name = test_name(t);
        exp_q.delete();
        clear_rom();
        preload_ram();
        load_program(t);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_quiet("in the first cycle after reset");
        @(negedge clk);
        assert (imem_req_o && imem_addr_o == RESET_PC) else begin
            $display("ERR %s: first fetch expected %h actual %h (req %b)", cur_name,
                     RESET_PC, imem_addr_o, imem_req_o);
            err_count++;
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (err_count != errs_before) begin
            fail_count++;
        end
        $display("test %-16s %s, %0d errors", cur_name,
                 (err_count == errs_before) ? "ok" : "FAILED", err_count - errs_before);
    endtask

    initial begin
        int limit;
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 8 * prog_words(t) + 50 + RESET_CYCLES + DRAIN_CYCLES + 4;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        imem_rdata_i = '0;
        dmem_rdata_i = '0;
        err_count    = 0;
        fail_count   = 0;
        check_count  = 0;
        cur_name     = "startup";
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d failed, %0d events checked, %0d errors",
                 NUM_TESTS, fail_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              imem_req_o,
    output rv_pkg::word_t     imem_addr_o,
    input  rv_pkg::word_t     imem_rdata_i,
    output logic              dmem_re_o,
    output logic              dmem_we_o,
    output rv_pkg::word_t     dmem_addr_o,
    output rv_pkg::word_t     dmem_wdata_o,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::word_t     wb_data_o
);

    rv_pkg::redirect_t redirect;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::fwd_t      ex_fwd;
    rv_pkg::fwd_t      mem_fwd;
    rv_pkg::word_t     id_pc;
    rv_pkg::word_t     id_inst;
    rv_pkg::word_t     rf_rdata1;
    rv_pkg::word_t     rf_rdata2;
    rv_pkg::reg_addr_t rf_raddr1;
    rv_pkg::reg_addr_t rf_raddr2;
    logic              id_valid;
    logic              stall;
    logic              flush;
    logic              rs1_used;
    logic              rs2_used;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .stall_i(stall),
        .flush_i(flush),
        .redirect_i(redirect),
        .imem_rdata_i(imem_rdata_i),
        .imem_req_o(imem_req_o),
        .imem_addr_o(imem_addr_o),
        .id_valid_o(id_valid),
        .id_pc_o(id_pc),
        .id_inst_o(id_inst)
    );

    // retiring writes double as the probe
    regfile u_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .we_i(wb_we_o),
        .waddr_i(wb_rd_o),
        .wdata_i(wb_data_o),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2)
    );

    decode_stage u_decode (
        .clk(clk),
        .rst_n(rst_n),
        .valid_i(id_valid),
        .pc_i(id_pc),
        .inst_i(id_inst),
        .stall_i(stall),
        .flush_i(flush),
        .rf_rdata1_i(rf_rdata1),
        .rf_rdata2_i(rf_rdata2),
        .ex_fwd_i(ex_fwd),
        .mem_fwd_i(mem_fwd),
        .rf_raddr1_o(rf_raddr1),
        .rf_raddr2_o(rf_raddr2),
        .rs1_used_o(rs1_used),
        .rs2_used_o(rs2_used),
        .id_ex_o(id_ex)
    );

    hazard_ctrl u_hazard (
        .id_valid_i(id_valid),
        .rf_raddr1_i(rf_raddr1),
        .rf_raddr2_i(rf_raddr2),
        .rs1_used_i(rs1_used),
        .rs2_used_i(rs2_used),
        .id_ex_i(id_ex),
        .ex_mem_i(ex_mem),
        .redirect_i(redirect),
        .stall_o(stall),
        .flush_o(flush)
    );

    execute_stage u_execute (
        .clk(clk),
        .rst_n(rst_n),
        .id_ex_i(id_ex),
        .redirect_o(redirect),
        .ex_fwd_o(ex_fwd),
        .ex_mem_o(ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk),
        .rst_n(rst_n),
        .ex_mem_i(ex_mem),
        .dmem_rdata_i(dmem_rdata_i),
        .dmem_re_o(dmem_re_o),
        .dmem_we_o(dmem_we_o),
        .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o),
        .mem_fwd_o(mem_fwd),
        .rf_we_o(wb_we_o),
        .rf_waddr_o(wb_rd_o),
        .rf_wdata_o(wb_data_o)
    );

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::ex_mem_t   ex_mem_i,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              dmem_re_o,
    output logic              dmem_we_o,
    output rv_pkg::word_t     dmem_addr_o,
    output rv_pkg::word_t     dmem_wdata_o,
    output rv_pkg::fwd_t      mem_fwd_o,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output rv_pkg::word_t     rf_wdata_o
);

    rv_pkg::mem_wb_t mem_wb_q;

    assign dmem_re_o    = ex_mem_i.valid && ex_mem_i.is_load;
    assign dmem_we_o    = ex_mem_i.valid && ex_mem_i.is_store;
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;

    assign mem_fwd_o.valid = ex_mem_i.valid && ex_mem_i.rd_we && !ex_mem_i.is_load;
    assign mem_fwd_o.rd    = ex_mem_i.rd;
    assign mem_fwd_o.data  = ex_mem_i.result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.valid   <= ex_mem_i.valid;
            mem_wb_q.rd      <= ex_mem_i.rd;
            mem_wb_q.rd_we   <= ex_mem_i.rd_we;
            mem_wb_q.is_load <= ex_mem_i.is_load;
            mem_wb_q.result  <= ex_mem_i.result;
        end
    end

    // read data shows up the cycle after the MEM request
    assign rf_we_o    = mem_wb_q.valid && mem_wb_q.rd_we;
    assign rf_waddr_o = mem_wb_q.rd;
    assign rf_wdata_o = mem_wb_q.is_load ? dmem_rdata_i : mem_wb_q.result;

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::id_ex_t    id_ex_i,
    output rv_pkg::redirect_t redirect_o,
    output rv_pkg::fwd_t      ex_fwd_o,
    output rv_pkg::ex_mem_t   ex_mem_o
);

    rv_pkg::word_t   op_a;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   alu_res;
    rv_pkg::word_t   result;
    rv_pkg::word_t   jalr_sum;
    logic [4:0]      shamt;
    logic            rs_eq;
    logic            rs_lt;
    logic            cond;
    logic            is_jump;
    rv_pkg::ex_mem_t ex_mem_q;

    assign op_a  = id_ex_i.a_zero ? '0 : (id_ex_i.a_pc ? id_ex_i.pc : id_ex_i.rs1);
    assign op_b  = id_ex_i.b_imm ? id_ex_i.imm : id_ex_i.rs2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pkg::ALU_AND:  alu_res = op_a & op_b;
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT:  alu_res = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU: alu_res = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            default:          alu_res = op_a + op_b;
        endcase
    end

    // branch compare works on the raw sources
    assign rs_eq = id_ex_i.rs1 == id_ex_i.rs2;
    assign rs_lt = $signed(id_ex_i.rs1) < $signed(id_ex_i.rs2);

    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  cond = rs_eq;
            3'b001:  cond = !rs_eq;
            3'b100:  cond = rs_lt;
            3'b101:  cond = !rs_lt;
            default: cond = 1'b0;
        endcase
    end

    assign is_jump  = id_ex_i.is_jal || id_ex_i.is_jalr;
    assign jalr_sum = id_ex_i.rs1 + id_ex_i.imm;
    assign result   = is_jump ? id_ex_i.pc + 32'd4 : alu_res;

    assign redirect_o.taken  = id_ex_i.valid && ((id_ex_i.is_branch && cond) || is_jump);
    assign redirect_o.target = id_ex_i.is_jalr ? {jalr_sum[31:1], 1'b0}
                                               : id_ex_i.pc + id_ex_i.imm;

    // a load has no value yet
    assign ex_fwd_o.valid = id_ex_i.valid && id_ex_i.rd_we && !id_ex_i.is_load;
    assign ex_fwd_o.rd    = id_ex_i.rd;
    assign ex_fwd_o.data  = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.pc         <= id_ex_i.pc;
            ex_mem_q.result     <= result;
            ex_mem_q.store_data <= id_ex_i.rs2;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.rd_we      <= id_ex_i.rd_we;
            ex_mem_q.is_load    <= id_ex_i.is_load;
            ex_mem_q.is_store   <= id_ex_i.is_store;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

// File: logic/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic              id_valid_i,
    input  rv_pkg::reg_addr_t rf_raddr1_i,
    input  rv_pkg::reg_addr_t rf_raddr2_i,
    input  logic              rs1_used_i,
    input  logic              rs2_used_i,
    input  rv_pkg::id_ex_t    id_ex_i,
    input  rv_pkg::ex_mem_t   ex_mem_i,
    input  rv_pkg::redirect_t redirect_i,
    output logic              stall_o,
    output logic              flush_o
);

    logic ex_hit;
    logic mem_hit;

    function automatic logic reads_rd(input logic used1, input rv_pkg::reg_addr_t addr1,
                                      input logic used2, input rv_pkg::reg_addr_t addr2,
                                      input rv_pkg::reg_addr_t rd);
        return (used1 && addr1 == rd) || (used2 && addr2 == rd);
    endfunction

    // load data only lands in WB, so a load still in MEM blocks too
    assign ex_hit  = id_ex_i.valid && id_ex_i.is_load && id_ex_i.rd_we
                     && reads_rd(rs1_used_i, rf_raddr1_i, rs2_used_i, rf_raddr2_i, id_ex_i.rd);
    assign mem_hit = ex_mem_i.valid && ex_mem_i.is_load && ex_mem_i.rd_we
                     && reads_rd(rs1_used_i, rf_raddr1_i, rs2_used_i, rf_raddr2_i, ex_mem_i.rd);

    assign flush_o = redirect_i.taken;
    assign stall_o = id_valid_i && (ex_hit || mem_hit) && !redirect_i.taken;

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     inst_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  rv_pkg::word_t     rf_rdata1_i,
    input  rv_pkg::word_t     rf_rdata2_i,
    input  rv_pkg::fwd_t      ex_fwd_i,
    input  rv_pkg::fwd_t      mem_fwd_i,
    output rv_pkg::reg_addr_t rf_raddr1_o,
    output rv_pkg::reg_addr_t rf_raddr2_o,
    output logic              rs1_used_o,
    output logic              rs2_used_o,
    output rv_pkg::id_ex_t    id_ex_o
);

    rv_pkg::opcode_e opcode;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    rv_pkg::id_ex_t  dec;
    rv_pkg::id_ex_t  id_ex_q;
    logic            wr;

    assign opcode      = rv_pkg::opcode_e'(inst_i[6:0]);
    assign rf_raddr1_o = inst_i[19:15];
    assign rf_raddr2_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // sub only exists in the register form
    function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    // EX beats MEM beats the register file
    function automatic rv_pkg::word_t operand(input rv_pkg::reg_addr_t addr,
                                              input rv_pkg::word_t rf_data);
        if (ex_fwd_i.valid && ex_fwd_i.rd == addr) begin
            return ex_fwd_i.data;
        end
        if (mem_fwd_i.valid && mem_fwd_i.rd == addr) begin
            return mem_fwd_i.data;
        end
        return rf_data;
    endfunction

    always_comb begin
        dec        = '0;
        wr         = 1'b0;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        dec.valid  = valid_i;
        dec.pc     = pc_i;
        dec.rd     = inst_i[11:7];
        dec.funct3 = inst_i[14:12];
        dec.alu_op = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OP_LUI: begin
                wr = 1'b1;
                dec.a_zero = 1'b1;
                dec.b_imm  = 1'b1;
                dec.imm    = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                wr = 1'b1;
                dec.a_pc  = 1'b1;
                dec.b_imm = 1'b1;
                dec.imm   = imm_u;
            end
            rv_pkg::OP_JAL: begin
                wr = 1'b1;
                dec.is_jal = 1'b1;
                dec.imm    = imm_j;
            end
            rv_pkg::OP_JALR: begin
                wr = 1'b1;
                rs1_used_o  = 1'b1;
                dec.is_jalr = 1'b1;
                dec.imm     = imm_i;
            end
            rv_pkg::OP_BRANCH: begin
                rs1_used_o    = 1'b1;
                rs2_used_o    = 1'b1;
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;
            end
            rv_pkg::OP_LOAD: begin
                wr = 1'b1;
                rs1_used_o  = 1'b1;
                dec.is_load = 1'b1;
                dec.b_imm   = 1'b1;
                dec.imm     = imm_i;
            end
            rv_pkg::OP_STORE: begin
                rs1_used_o   = 1'b1;
                rs2_used_o   = 1'b1;
                dec.is_store = 1'b1;
                dec.b_imm    = 1'b1;
                dec.imm      = imm_s;
            end
            rv_pkg::OP_IMM: begin
                wr = 1'b1;
                rs1_used_o = 1'b1;
                dec.b_imm  = 1'b1;
                dec.imm    = imm_i;
                dec.alu_op = alu_decode(inst_i[14:12], inst_i[30], 1'b0);
            end
            rv_pkg::OP_REG: begin
                wr = 1'b1;
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                dec.alu_op = alu_decode(inst_i[14:12], inst_i[30], 1'b1);
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        // writes to x0 are dropped here
        dec.rd_we = wr && (dec.rd != '0);
        dec.rs1   = operand(rf_raddr1_o, rf_rdata1_i);
        dec.rs2   = operand(rf_raddr2_o, rf_rdata2_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= dec;
            if (stall_i || flush_i) begin
                id_ex_q.valid <= 1'b0;
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o
);

    rv_pkg::word_t regs [31:1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, same-cycle write is passed through
    assign rdata1_o = (raddr1_i == '0) ? '0
                    : (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0
                    : (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall_i,
    input  logic              flush_i,
    input  rv_pkg::redirect_t redirect_i,
    input  rv_pkg::word_t     imem_rdata_i,
    output logic              imem_req_o,
    output rv_pkg::word_t     imem_addr_o,
    output logic              id_valid_o,
    output rv_pkg::word_t     id_pc_o,
    output rv_pkg::word_t     id_inst_o
);

    rv_pkg::word_t pc_q;
    rv_pkg::word_t id_pc_q;
    rv_pkg::word_t hold_q;
    logic          run_q;
    logic          id_valid_q;
    logic          use_hold_q;

    // first request goes out one edge after reset release
    assign imem_req_o  = run_q;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            pc_q       <= RESET_PC;
            id_valid_q <= 1'b0;
            use_hold_q <= 1'b0;
        end else begin
            run_q      <= 1'b1;
            use_hold_q <= stall_i && !flush_i;
            if (redirect_i.taken) begin
                pc_q <= redirect_i.target;
            end else if (run_q && !stall_i) begin
                pc_q <= pc_q + 32'd4;
            end
            if (flush_i) begin
                id_valid_q <= 1'b0;
            end else if (!stall_i) begin
                id_valid_q <= run_q;
            end
        end
    end

    // memory has moved on during a stall, keep the word ID is looking at
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_q <= pc_q;
        end
        if (stall_i) begin
            hold_q <= id_inst_o;
        end
    end

    assign id_valid_o = id_valid_q;
    assign id_pc_o    = id_pc_q;
    assign id_inst_o  = use_hold_q ? hold_q : imem_rdata_i;

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // major opcodes still decoded, anything else is a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        word_t     imm;
        reg_addr_t rd;
        logic      rd_we;
        alu_op_e   alu_op;
        logic      a_pc;
        logic      a_zero;
        logic      b_imm;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic [2:0] funct3;
        logic      is_load;
        logic      is_store;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_load;
        word_t     result;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage
